/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // Data bits per character, no parity
    localparam int DATA_BITS = 8;

    // One serial character
    typedef logic [DATA_BITS - 1 : 0] uart_byte_t;

endpackage

`default_nettype wire

/* rtl/monitor_pkg.sv */
`default_nettype none

package monitor_pkg;

    // Memory map
    localparam int ADDR_BITS = 8;
    localparam int MEM_DEPTH = 1 << ADDR_BITS;

    typedef logic [ADDR_BITS - 1 : 0] addr_t;
    typedef logic [7:0]               word_t;

    // First byte of every three-byte frame
    typedef enum logic [7:0] {
        CMD_READ  = 8'hA3,
        CMD_WRITE = 8'h5C,
        CMD_PING  = 8'hF0
    } cmd_t;

    // Fixed answer to a ping
    localparam word_t PING_REPLY = 8'hAA;

endpackage

`default_nettype wire

/* rtl/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
    import monitor_pkg::*;

    addr_t addr;
    word_t wdata;
    logic  we;
    word_t rdata;

    // Sequencer side
    modport ctrl (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    // Memory side, rdata follows addr in the same cycle
    modport mem (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLK_BITS = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [CLK_BITS - 1 : 0] clk_per_bit,
    input  logic                    rxd,
    output uart_pkg::uart_byte_t    rx_data,
    output logic                    rx_valid
);
    import uart_pkg::*;

    localparam int IDX_BITS = $clog2(DATA_BITS);
    localparam logic [IDX_BITS - 1 : 0] LAST_BIT = IDX_BITS'(DATA_BITS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_RECEIVE,
        RX_STOP
    } rx_state_t;

    rx_state_t               state;
    logic                    rx_meta;
    logic                    rx_sync;
    logic                    rx_prev;
    logic [CLK_BITS - 1 : 0] clk_cnt;
    logic [CLK_BITS - 1 : 0] half_period;
    logic                    period_end;
    logic [IDX_BITS - 1 : 0] bit_idx;
    uart_byte_t              shift_reg;

    // Line idles high, so the synchronizer resets to one
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign half_period = (clk_per_bit - 1'b1) >> 1;
    assign period_end  = (clk_cnt == clk_per_bit - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    // Falling edge marks the start bit
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end

                RX_START: begin
                    if (clk_cnt == half_period) begin
                        clk_cnt <= '0;
                        // Line back high means a glitch, not a start bit
                        state   <= rx_sync ? RX_IDLE : RX_RECEIVE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                RX_RECEIVE: begin
                    if (period_end) begin
                        clk_cnt   <= '0;
                        // LSB arrives first
                        shift_reg <= {rx_sync, shift_reg[DATA_BITS - 1 : 1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                RX_STOP: begin
                    if (period_end) begin
                        clk_cnt  <= '0;
                        rx_data  <= shift_reg;
                        rx_valid <= 1'b1;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLK_BITS  = 10,
    parameter int STOP_BITS = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [CLK_BITS - 1 : 0] clk_per_bit,
    input  uart_pkg::uart_byte_t    tx_data,
    input  logic                    tx_start,
    output logic                    txd,
    output logic                    tx_busy,
    output logic                    tx_done
);
    import uart_pkg::*;

    // Start bit, data, stop bits
    localparam int FRAME_BITS = 1 + DATA_BITS + STOP_BITS;
    localparam int CNT_BITS   = $clog2(FRAME_BITS);

    logic [FRAME_BITS - 1 : 0] frame;
    logic [CLK_BITS - 1 : 0]   clk_cnt;
    logic [CNT_BITS - 1 : 0]   bits_left;
    logic                      period_end;

    assign period_end = (clk_cnt == clk_per_bit - 1'b1);

    // Bit zero of the frame register is the line itself
    assign txd = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            frame     <= '1;
            clk_cnt   <= '0;
            bits_left <= '0;
            tx_busy   <= 1'b0;
            tx_done   <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                clk_cnt <= '0;
                if (tx_start) begin
                    frame     <= {{STOP_BITS{1'b1}}, tx_data, 1'b0};
                    bits_left <= CNT_BITS'(FRAME_BITS - 1);
                    tx_busy   <= 1'b1;
                end
            end else if (period_end) begin
                clk_cnt <= '0;
                // Shift in ones so the line returns to idle
                frame   <= {1'b1, frame[FRAME_BITS - 1 : 1]};
                if (bits_left == '0) begin
                    tx_busy <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    bits_left <= bits_left - 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/monitor_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module monitor_ram (
    input  logic   clk,
    mem_port_if.mem mem
);
    import monitor_pkg::*;

    word_t ram [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.addr] <= mem.wdata;
        end
    end

    // Asynchronous read port
    assign mem.rdata = ram[mem.addr];

endmodule

`default_nettype wire

/* rtl/command_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module command_monitor (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t rx_data,
    input  logic                 rx_valid,
    output uart_pkg::uart_byte_t tx_data,
    output logic                 tx_start,
    input  logic                 tx_done,
    mem_port_if.ctrl             mem
);
    import uart_pkg::*;
    import monitor_pkg::*;

    typedef enum logic [2:0] {
        S_WAIT_CMD,
        S_WAIT_ADDR,
        S_WAIT_DATA,
        S_EXEC,
        S_SEND,
        S_SEND_WAIT
    } state_t;

    state_t     state;
    state_t     state_next;

    // Captured frame
    uart_byte_t cmd_byte;
    addr_t      addr_byte;
    word_t      data_byte;

    uart_byte_t reply;
    uart_byte_t reply_next;

    always_comb begin
        state_next = state;
        reply_next = reply;

        case (state)
            S_WAIT_CMD: begin
                if (rx_valid) begin
                    state_next = S_WAIT_ADDR;
                end
            end

            S_WAIT_ADDR: begin
                if (rx_valid) begin
                    state_next = S_WAIT_DATA;
                end
            end

            S_WAIT_DATA: begin
                if (rx_valid) begin
                    state_next = S_EXEC;
                end
            end

            S_EXEC: begin
                // Writes and unknown commands go straight back
                state_next = S_WAIT_CMD;
                case (cmd_byte)
                    CMD_READ: begin
                        reply_next = mem.rdata;
                        state_next = S_SEND;
                    end
                    CMD_PING: begin
                        reply_next = PING_REPLY;
                        state_next = S_SEND;
                    end
                    default: ;
                endcase
            end

            S_SEND: begin
                state_next = S_SEND_WAIT;
            end

            S_SEND_WAIT: begin
                // Bytes arriving here are dropped
                if (tx_done) begin
                    state_next = S_WAIT_CMD;
                end
            end

            default: state_next = S_WAIT_CMD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_WAIT_CMD;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                S_WAIT_CMD:  cmd_byte  <= rx_data;
                S_WAIT_ADDR: addr_byte <= rx_data;
                S_WAIT_DATA: data_byte <= rx_data;
                default: ;
            endcase
        end
        if (state == S_EXEC) begin
            reply <= reply_next;
        end
    end

    // Memory port follows the captured address
    assign mem.addr  = addr_byte;
    assign mem.wdata = data_byte;
    assign mem.we    = (state == S_EXEC) && (cmd_byte == CMD_WRITE);

    assign tx_start  = (state == S_SEND);
    assign tx_data   = reply;

endmodule

`default_nettype wire

/* rtl/uart_monitor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_monitor_top #(
    parameter int CLK_BITS  = 10,
    parameter int STOP_BITS = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [CLK_BITS - 1 : 0] clk_per_bit,
    input  logic                    uart_rx,
    output logic                    uart_tx
);
    import uart_pkg::*;

    uart_byte_t rx_data;
    logic       rx_valid;
    uart_byte_t tx_data;
    logic       tx_start;
    logic       tx_done;

    mem_port_if mem_port ();

    uart_rx #(
        .CLK_BITS(CLK_BITS)
    ) uart_rx_i (
        .clk        (clk),
        .rst        (rst),
        .clk_per_bit(clk_per_bit),
        .rxd        (uart_rx),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid)
    );

    // The sequencer paces itself on tx_done, so busy stays open
    uart_tx #(
        .CLK_BITS (CLK_BITS),
        .STOP_BITS(STOP_BITS)
    ) uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .clk_per_bit(clk_per_bit),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .txd        (uart_tx),
        .tx_busy    (),
        .tx_done    (tx_done)
    );

    command_monitor command_monitor_i (
        .clk     (clk),
        .rst     (rst),
        .rx_data (rx_data),
        .rx_valid(rx_valid),
        .tx_data (tx_data),
        .tx_start(tx_start),
        .tx_done (tx_done),
        .mem     (mem_port)
    );

    monitor_ram monitor_ram_i (
        .clk(clk),
        .mem(mem_port)
    );

endmodule

`default_nettype wire

/* bench/uart_monitor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_monitor_tb;

    localparam int BIT_CYCLES = 16;
    localparam int FRAME_PERIODS = 30;
    localparam int REPLY_TIMEOUT = (FRAME_PERIODS + 20) * BIT_CYCLES;
    localparam logic [7:0] READ_CMD = 8'hA3;
    localparam logic [7:0] WRITE_CMD = 8'h5C;
    localparam logic [7:0] PING_CMD = 8'hF0;
    localparam logic [7:0] PING_ANSWER = 8'hAA;

    logic       clk;
    logic       rst;
    logic [9:0] clk_per_bit;
    logic       uart_rx;
    logic       uart_tx;

    integer seed;
    int     errors;
    int     checks;

    // Reference memory, only written entries are compared
    logic [7:0] model_mem [256];
    bit         model_written [256];
    logic [7:0] written_addrs [$];

    uart_monitor_top #(
        .CLK_BITS (10),
        .STOP_BITS(1)
    ) uart_monitor_top_i (
        .clk        (clk),
        .rst        (rst),
        .clk_per_bit(clk_per_bit),
        .uart_rx    (uart_rx),
        .uart_tx    (uart_tx)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0t %s: expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [7:0] pick_written();
        integer r;
        r = $random(seed);
        return written_addrs[$unsigned(r) % written_addrs.size()];
    endfunction

    // Any command byte outside the three known ones
    function automatic logic [7:0] draw_bad_cmd();
        logic [7:0] c;
        c = rand_byte();
        while (c == READ_CMD || c == WRITE_CMD || c == PING_CMD) begin
            c = rand_byte();
        end
        return c;
    endfunction

    // Called on a falling edge, returns on a falling edge
    task automatic send_byte(input logic [7:0] b);
        int i;
        uart_rx = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            uart_rx = b[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        uart_rx = 1'b1;
        repeat (BIT_CYCLES) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [7:0] addr,
                              input logic [7:0] data);
        send_byte(cmd);
        send_byte(addr);
        send_byte(data);
    endtask

    task automatic receive_byte(output bit got, output logic [7:0] data);
        int cnt;
        int i;
        got = 1'b0;
        data = '0;
        cnt = 0;
        while (uart_tx !== 1'b0 && cnt < REPLY_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (uart_tx !== 1'b0) begin
            errors++;
            $display("Timeout at %0t: no reply start bit on uart_tx", $time);
        end else begin
            // Move to the middle of the start bit
            repeat (BIT_CYCLES / 2 - 1) @(negedge clk);
            check_value("uart_tx start bit", 8'h00, {7'b0, uart_tx});
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                data[i] = uart_tx;
            end
            repeat (BIT_CYCLES) @(negedge clk);
            check_value("uart_tx stop bit", 8'h01, {7'b0, uart_tx});
            got = 1'b1;
        end
    endtask

    task automatic expect_silence(input int periods);
        int  cnt;
        bit  seen;
        cnt = 0;
        seen = 1'b0;
        while (!seen && cnt < periods * BIT_CYCLES) begin
            @(negedge clk);
            cnt++;
            if (uart_tx !== 1'b1) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            errors++;
            $display("Unexpected start bit on uart_tx at %0t", $time);
        end
    endtask

    task automatic ping_and_check(input logic [7:0] addr, input logic [7:0] data);
        bit         got;
        logic [7:0] reply;
        fork
            send_frame(PING_CMD, addr, data);
            receive_byte(got, reply);
        join
        if (got) begin
            check_value("ping reply", PING_ANSWER, reply);
        end
    endtask

    task automatic read_and_check(input logic [7:0] addr);
        bit         got;
        logic [7:0] reply;
        fork
            send_frame(READ_CMD, addr, rand_byte());
            receive_byte(got, reply);
        join
        if (got) begin
            check_value("read reply", model_mem[addr], reply);
        end
    endtask

    task automatic write_and_update(input logic [7:0] addr, input logic [7:0] data);
        fork
            send_frame(WRITE_CMD, addr, data);
            expect_silence(FRAME_PERIODS + 10);
        join
        if (!model_written[addr]) begin
            written_addrs.push_back(addr);
        end
        model_written[addr] = 1'b1;
        model_mem[addr] = data;
    endtask

    // Data byte differs from the stored value, so a stray write would show
    task automatic send_unknown_cmd(input logic [7:0] cmd, input logic [7:0] addr);
        fork
            send_frame(cmd, addr, ~model_mem[addr]);
            expect_silence(FRAME_PERIODS + 40);
        join
    endtask

    initial begin
        logic [7:0] a;
        int         kind;
        int         i;
        seed = 85797;
        errors = 0;
        checks = 0;
        clk = 1'b0;
        rst = 1'b1;
        uart_rx = 1'b1;
        clk_per_bit = BIT_CYCLES;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Idle line after reset
        expect_silence(40);

        // Single ping, then no second byte
        ping_and_check(rand_byte(), rand_byte());
        expect_silence(20);

        // Write then read back
        for (i = 0; i < 30; i++) begin
            a = rand_byte();
            write_and_update(a, rand_byte());
            read_and_check(a);
        end

        // Overwrites mixed with fresh addresses, then scattered reads
        for (i = 0; i < 10; i++) begin
            a = (i % 2 == 0) ? pick_written() : rand_byte();
            write_and_update(a, rand_byte());
        end
        for (i = 0; i < 15; i++) begin
            read_and_check(pick_written());
        end

        // Unknown commands aimed at tracked addresses must not touch memory
        for (i = 0; i < 8; i++) begin
            a = pick_written();
            send_unknown_cmd(draw_bad_cmd(), a);
            read_and_check(a);
        end
        for (i = 0; i < 8; i++) begin
            read_and_check(pick_written());
        end

        // Mixed traffic
        for (i = 0; i < 20; i++) begin
            kind = $unsigned($random(seed)) % 3;
            case (kind)
                0: ping_and_check(rand_byte(), rand_byte());
                1: read_and_check(pick_written());
                default: write_and_update(rand_byte(), rand_byte());
            endcase
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/uart_pkg.sv
rtl/monitor_pkg.sv
rtl/mem_port_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/monitor_ram.sv
rtl/command_monitor.sv
rtl/uart_monitor_top.sv
bench/uart_monitor_tb.sv

/* Bender.yml */
package:
  name: uart_monitor

sources:
  - rtl/uart_pkg.sv
  - rtl/monitor_pkg.sv
  - rtl/mem_port_if.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/monitor_ram.sv
  - rtl/command_monitor.sv
  - rtl/uart_monitor_top.sv
  - target: test
    files:
      - bench/uart_monitor_tb.sv
